// ==== common/int_pkg.sv ====
`default_nettype none

package int_pkg;

    localparam int XLEN       = 16;
    localparam int NUM_PREGS  = 32;
    localparam int PREG_W     = 5;
    localparam int NUM_SRCS   = 2;
    localparam int DISP_WIDTH = 2;
    localparam int IQ_DEPTH   = 4;
    localparam int NUM_PIPES  = 2;
    localparam int IQ_IDX_W   = $clog2(IQ_DEPTH);

    typedef logic [PREG_W-1:0] preg_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7
    } alu_op_e;

    // renamed micro-op, immediate carried inline
    typedef struct packed {
        alu_op_e                  op;
        logic                     use_imm;
        logic [XLEN-1:0]          imm;
        preg_t [NUM_SRCS-1:0]     src;
        logic [NUM_SRCS-1:0]      src_rdy;
        preg_t                    dst;
    } int_uop_t;

    function automatic logic [XLEN-1:0] alu_exec(
        input alu_op_e         op,
        input logic [XLEN-1:0] a,
        input logic [XLEN-1:0] b
    );
        logic [XLEN-1:0] res;
        case (op)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            // shift amount from the low bits only
            ALU_SLL: res = a << b[$clog2(XLEN)-1:0];
            ALU_SRL: res = a >> b[$clog2(XLEN)-1:0];
            ALU_SLT: res = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
            default: res = '0;
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== common/exe_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exe_if import int_pkg::*; ();

    // operand read in s0
    preg_t                  rd_preg [NUM_SRCS];
    logic [XLEN-1:0]        rd_data [NUM_SRCS];

    // early wakeup from s1
    logic                   wake_vld;
    preg_t                  wake_preg;

    // writeback stage
    logic                   wb_vld;
    preg_t                  wb_preg;
    logic [XLEN-1:0]        wb_data;

    // wakeups of all pipes, seen by every queue
    logic [NUM_PIPES-1:0]   bc_wake_vld;
    preg_t                  bc_wake_preg [NUM_PIPES];

    modport pipe (
        output rd_preg, wake_vld, wake_preg, wb_vld, wb_preg, wb_data,
        input  rd_data, bc_wake_vld, bc_wake_preg
    );

    modport net (
        input  rd_preg, wake_vld, wake_preg, wb_vld, wb_preg, wb_data,
        output rd_data, bc_wake_vld, bc_wake_preg
    );

endinterface

`default_nettype wire

// ==== issue_pipe/issue_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_queue import int_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    i_enq_vld,
    input  int_uop_t                i_enq_uop,
    input  logic [NUM_PIPES-1:0]    i_wake_vld,
    input  preg_t                   i_wake_preg [NUM_PIPES],
    output logic                    o_has_free,
    output logic                    o_iss_vld,
    output int_uop_t                o_iss_uop
);

    logic [IQ_DEPTH-1:0]    ent_vld;
    int_uop_t               ent_uop [IQ_DEPTH];
    // rank among valid entries, highest is oldest
    logic [IQ_IDX_W-1:0]    ent_age [IQ_DEPTH];

    // pregs broadcast since reset
    // each is written only once, so a set bit stays true
    logic [NUM_PREGS-1:0]   woken;

    logic                   enq_fire;
    logic [IQ_IDX_W-1:0]    free_idx;
    logic [IQ_IDX_W-1:0]    sel_idx;
    logic [IQ_DEPTH-1:0]    age_dec;

    function automatic logic [NUM_SRCS-1:0] wake_rdy(input int_uop_t u);
        logic [NUM_SRCS-1:0] rdy;
        rdy = u.src_rdy;
        // immediate replaces the second source
        rdy[1] = rdy[1] | u.use_imm;
        for (int s = 0; s < NUM_SRCS; s++) begin
            rdy[s] = rdy[s] | woken[u.src[s]];
            for (int p = 0; p < NUM_PIPES; p++) begin
                if (i_wake_vld[p] && i_wake_preg[p] == u.src[s]) begin
                    rdy[s] = 1'b1;
                end
            end
        end
        return rdy;
    endfunction

    assign o_has_free = ~&ent_vld;
    assign enq_fire   = i_enq_vld && o_has_free;

    // lowest free slot
    always_comb begin
        free_idx = '0;
        for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
            if (!ent_vld[i]) begin
                free_idx = IQ_IDX_W'(i);
            end
        end
    end

    // oldest entry with all sources ready
    always_comb begin
        o_iss_vld = 1'b0;
        sel_idx   = '0;
        for (int i = 0; i < IQ_DEPTH; i++) begin
            if (ent_vld[i] && &ent_uop[i].src_rdy &&
                (!o_iss_vld || ent_age[i] > ent_age[sel_idx])) begin
                o_iss_vld = 1'b1;
                sel_idx   = IQ_IDX_W'(i);
            end
        end
    end

    assign o_iss_uop = ent_uop[sel_idx];

    // entries older than the issued one move down a rank
    always_comb begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            age_dec[i] = o_iss_vld && (ent_age[i] > ent_age[sel_idx]);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ent_vld <= '0;
            woken   <= '0;
        end else begin
            for (int p = 0; p < NUM_PIPES; p++) begin
                if (i_wake_vld[p]) begin
                    woken[i_wake_preg[p]] <= 1'b1;
                end
            end
            for (int i = 0; i < IQ_DEPTH; i++) begin
                if (o_iss_vld && sel_idx == IQ_IDX_W'(i)) begin
                    ent_vld[i] <= 1'b0;
                end else if (enq_fire && free_idx == IQ_IDX_W'(i)) begin
                    ent_vld[i] <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < IQ_DEPTH; i++) begin
            ent_uop[i].src_rdy <= wake_rdy(ent_uop[i]);
            ent_age[i] <= ent_age[i] + IQ_IDX_W'(enq_fire) - IQ_IDX_W'(age_dec[i]);
            if (enq_fire && free_idx == IQ_IDX_W'(i)) begin
                ent_uop[i]         <= i_enq_uop;
                ent_uop[i].src_rdy <= wake_rdy(i_enq_uop);
                // newest entry
                ent_age[i]         <= '0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== issue_pipe/issue_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_pipe import int_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        i_enq_vld,
    input  int_uop_t    i_enq_uop,
    output logic        o_has_free,
    exe_if.pipe         bus
);

    logic               iss_vld;
    int_uop_t           iss_uop;

    // s1 stage
    logic               s1_vld;
    int_uop_t           s1_uop;
    logic [XLEN-1:0]    s1_opnd [NUM_SRCS];
    logic [XLEN-1:0]    s1_opnd_b;
    logic [XLEN-1:0]    s1_result;

    // writeback stage
    logic               wb_vld;
    preg_t              wb_preg;
    logic [XLEN-1:0]    wb_data;

    issue_queue u_queue (
        .clk         (clk),
        .rst         (rst),
        .i_enq_vld   (i_enq_vld),
        .i_enq_uop   (i_enq_uop),
        .i_wake_vld  (bus.bc_wake_vld),
        .i_wake_preg (bus.bc_wake_preg),
        .o_has_free  (o_has_free),
        .o_iss_vld   (iss_vld),
        .o_iss_uop   (iss_uop)
    );

    // s0: regfile read with write-through
    always_comb begin
        for (int s = 0; s < NUM_SRCS; s++) begin
            bus.rd_preg[s] = iss_uop.src[s];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= iss_vld;
        end
    end

    always_ff @(posedge clk) begin
        s1_uop  <= iss_uop;
        s1_opnd <= bus.rd_data;
    end

    // s1: execute and wake dependents
    assign s1_opnd_b = s1_uop.use_imm ? s1_uop.imm : s1_opnd[1];
    assign s1_result = alu_exec(s1_uop.op, s1_opnd[0], s1_opnd_b);

    assign bus.wake_vld  = s1_vld;
    assign bus.wake_preg = s1_uop.dst;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_vld <= 1'b0;
        end else begin
            wb_vld <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        wb_preg <= s1_uop.dst;
        wb_data <= s1_result;
    end

    assign bus.wb_vld  = wb_vld;
    assign bus.wb_preg = wb_preg;
    assign bus.wb_data = wb_data;

endmodule

`default_nettype wire

// ==== hdl/writeback_net.sv ====
`timescale 1ns/1ps
`default_nettype none

module writeback_net import int_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    exe_if.net                      bus0,
    exe_if.net                      bus1,
    output logic [NUM_PIPES-1:0]    o_wb_vld,
    output preg_t                   o_wb_preg [NUM_PIPES],
    output logic [XLEN-1:0]         o_wb_data [NUM_PIPES]
);

    logic [XLEN-1:0]        regs [NUM_PREGS];

    logic [NUM_PIPES-1:0]   wb_vld;
    preg_t                  wb_preg [NUM_PIPES];
    logic [XLEN-1:0]        wb_data [NUM_PIPES];

    // gather both pipes
    assign wb_vld     = {bus1.wb_vld, bus0.wb_vld};
    assign wb_preg[0] = bus0.wb_preg;
    assign wb_preg[1] = bus1.wb_preg;
    assign wb_data[0] = bus0.wb_data;
    assign wb_data[1] = bus1.wb_data;

    // stored value, or the result being written this cycle
    function automatic logic [XLEN-1:0] rf_read(input preg_t idx);
        logic [XLEN-1:0] val;
        val = regs[idx];
        for (int p = 0; p < NUM_PIPES; p++) begin
            if (wb_vld[p] && wb_preg[p] == idx) begin
                val = wb_data[p];
            end
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            regs <= '{default: '0};
        end else begin
            for (int p = 0; p < NUM_PIPES; p++) begin
                if (wb_vld[p]) begin
                    regs[wb_preg[p]] <= wb_data[p];
                end
            end
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SRCS; s++) begin
            bus0.rd_data[s] = rf_read(bus0.rd_preg[s]);
            bus1.rd_data[s] = rf_read(bus1.rd_preg[s]);
        end
    end

    // early wakeups go to every queue
    assign bus0.bc_wake_vld     = {bus1.wake_vld, bus0.wake_vld};
    assign bus0.bc_wake_preg[0] = bus0.wake_preg;
    assign bus0.bc_wake_preg[1] = bus1.wake_preg;
    assign bus1.bc_wake_vld     = {bus1.wake_vld, bus0.wake_vld};
    assign bus1.bc_wake_preg[0] = bus0.wake_preg;
    assign bus1.bc_wake_preg[1] = bus1.wake_preg;

    assign o_wb_vld  = wb_vld;
    assign o_wb_preg = wb_preg;
    assign o_wb_data = wb_data;

endmodule

`default_nettype wire

// ==== hdl/int_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_block import int_pkg::*; (
    input  logic                    clk,
    input  logic                    rst,
    // dispatch
    input  logic [DISP_WIDTH-1:0]   i_disp_vld,
    input  int_uop_t                i_disp_uop [DISP_WIDTH],
    output logic [DISP_WIDTH-1:0]   o_disp_accept,
    // writeback
    output logic [NUM_PIPES-1:0]    o_wb_vld,
    output preg_t                   o_wb_preg [NUM_PIPES],
    output logic [XLEN-1:0]         o_wb_data [NUM_PIPES]
);

    logic [NUM_PIPES-1:0]   has_free;
    logic [NUM_PIPES-1:0]   enq_vld;
    int_uop_t               enq_uop [NUM_PIPES];

    logic slot0_to_q0;
    logic slot0_to_q1;
    logic slot1_to_q0;
    logic slot1_to_q1;
    logic slot1_allowed;

    // slot 0 prefers queue 0
    assign slot0_to_q0 = i_disp_vld[0] && has_free[0];
    assign slot0_to_q1 = i_disp_vld[0] && !has_free[0] && has_free[1];

    // keep acceptance in order
    assign slot1_allowed = slot0_to_q0 || slot0_to_q1 || !i_disp_vld[0];

    // slot 1 takes whichever queue slot 0 left
    assign slot1_to_q0 = i_disp_vld[1] && slot1_allowed && !slot0_to_q0 && has_free[0];
    assign slot1_to_q1 = i_disp_vld[1] && slot1_allowed && !slot0_to_q1 && !slot1_to_q0
                         && has_free[1];

    assign o_disp_accept = {slot1_to_q0 || slot1_to_q1, slot0_to_q0 || slot0_to_q1};

    assign enq_vld[0] = slot0_to_q0 || slot1_to_q0;
    assign enq_vld[1] = slot0_to_q1 || slot1_to_q1;
    assign enq_uop[0] = slot0_to_q0 ? i_disp_uop[0] : i_disp_uop[1];
    assign enq_uop[1] = slot0_to_q1 ? i_disp_uop[0] : i_disp_uop[1];

    exe_if u_bus0 ();
    exe_if u_bus1 ();

    issue_pipe u_pipe0 (
        .clk        (clk),
        .rst        (rst),
        .i_enq_vld  (enq_vld[0]),
        .i_enq_uop  (enq_uop[0]),
        .o_has_free (has_free[0]),
        .bus        (u_bus0)
    );

    issue_pipe u_pipe1 (
        .clk        (clk),
        .rst        (rst),
        .i_enq_vld  (enq_vld[1]),
        .i_enq_uop  (enq_uop[1]),
        .o_has_free (has_free[1]),
        .bus        (u_bus1)
    );

    writeback_net u_wb_net (
        .clk       (clk),
        .rst       (rst),
        .bus0      (u_bus0),
        .bus1      (u_bus1),
        .o_wb_vld  (o_wb_vld),
        .o_wb_preg (o_wb_preg),
        .o_wb_data (o_wb_data)
    );

endmodule

`default_nettype wire

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic o_clk,
    output logic o_rst
);

    localparam int HALF_PERIOD = 4;
    localparam int RST_CYCLES  = 2;

    initial begin
        o_clk = 1'b0;
        forever #HALF_PERIOD o_clk = ~o_clk;
    end

    // reset is seen high on the first two rising edges
    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/int_block_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_block_assertions import int_pkg::*; (
    input logic                                 clk,
    input logic                                 rst,
    input logic [NUM_PIPES-1:0]                 wb_vld,
    input logic [NUM_PIPES-1:0][PREG_W-1:0]     wb_preg,
    input logic [NUM_PIPES-1:0]                 wake_vld,
    input logic [NUM_PIPES-1:0][PREG_W-1:0]     wake_preg,
    input logic                                 enq_vld,
    input int_uop_t                             enq_uop,
    input logic                                 iss_vld,
    input int_uop_t                             iss_uop
);

    // read by the testbench top
    int unsigned fail_count = 0;

    // pregs seen ready at dispatch or broadcast since reset
    logic [NUM_PREGS-1:0]   avail;
    logic [NUM_SRCS-1:0]    iss_rdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            avail <= '0;
        end else begin
            for (int p = 0; p < NUM_PIPES; p++) begin
                if (wake_vld[p]) begin
                    avail[wake_preg[p]] <= 1'b1;
                end
            end
            if (enq_vld) begin
                for (int s = 0; s < NUM_SRCS; s++) begin
                    if (enq_uop.src_rdy[s] && (s == 0 || !enq_uop.use_imm)) begin
                        avail[enq_uop.src[s]] <= 1'b1;
                    end
                end
            end
        end
    end

    // immediate stands in for the second source
    always_comb begin
        for (int s = 0; s < NUM_SRCS; s++) begin
            iss_rdy[s] = avail[iss_uop.src[s]];
        end
        iss_rdy[1] = iss_rdy[1] | iss_uop.use_imm;
    end

    // two pipes retiring into one preg would lose a result
    wb_unique: assert property (@(posedge clk) disable iff (rst)
        &wb_vld |-> wb_preg[0] != wb_preg[1])
    else begin
        $error("both pipes wrote back preg %0d in one cycle", wb_preg[0]);
        fail_count++;
    end

    iss_ready: assert property (@(posedge clk) disable iff (rst)
        iss_vld |-> &iss_rdy)
    else begin
        $error("queue issued an entry with sources ready %b", iss_rdy);
        fail_count++;
    end

    wb_idle_after_reset: assert property (@(posedge clk)
        $past(rst) |-> wb_vld == '0)
    else begin
        $error("writeback valid %b right after reset", wb_vld);
        fail_count++;
    end

endmodule

`default_nettype wire

// ==== verif/int_block_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module int_block_tb import int_pkg::*; ();

    localparam int NUM_UOPS       = 30;
    localparam int NUM_FIELDS     = 9;
    // offers before this index get random gaps, the rest go back to back
    localparam int PAUSE_END      = 14;
    localparam int RESET_TIMEOUT  = 20;
    localparam int ACCEPT_TIMEOUT = 100;
    localparam int DRAIN_TIMEOUT  = 200;
    localparam int QUIET_CYCLES   = 8;
    localparam int SETTLE         = 1;

    logic                   clk;
    logic                   rst;
    logic [DISP_WIDTH-1:0]  disp_vld;
    int_uop_t               disp_uop [DISP_WIDTH];
    logic [DISP_WIDTH-1:0]  disp_accept;
    logic [NUM_PIPES-1:0]   wb_vld;
    preg_t                  wb_preg [NUM_PIPES];
    logic [XLEN-1:0]        wb_data [NUM_PIPES];

    logic [15:0]            tdata [NUM_UOPS*NUM_FIELDS];
    int_uop_t               uops [NUM_UOPS];
    // reference model, indexed by preg
    logic [XLEN-1:0]        exp_val [NUM_PREGS];
    logic [NUM_PREGS-1:0]   exp_known;
    logic [NUM_PREGS-1:0]   seen;
    int                     wb_count;
    int                     bp_cycles;
    int unsigned            lcg_state;

    tb_clock u_clock (
        .o_clk (clk),
        .o_rst (rst)
    );

    int_block uut (
        .clk           (clk),
        .rst           (rst),
        .i_disp_vld    (disp_vld),
        .i_disp_uop    (disp_uop),
        .o_disp_accept (disp_accept),
        .o_wb_vld      (wb_vld),
        .o_wb_preg     (wb_preg),
        .o_wb_data     (wb_data)
    );

    bind writeback_net int_block_assertions u_wb_asrt (
        .clk       (clk),
        .rst       (rst),
        .wb_vld    (o_wb_vld),
        .wb_preg   ({o_wb_preg[1], o_wb_preg[0]}),
        .wake_vld  ('0),
        .wake_preg ('0),
        .enq_vld   (1'b0),
        .enq_uop   ('0),
        .iss_vld   (1'b0),
        .iss_uop   ('0)
    );

    bind issue_queue int_block_assertions u_iq_asrt (
        .clk       (clk),
        .rst       (rst),
        .wb_vld    ('0),
        .wb_preg   ('0),
        .wake_vld  (i_wake_vld),
        .wake_preg ({i_wake_preg[1], i_wake_preg[0]}),
        .enq_vld   (enq_fire),
        .enq_uop   (i_enq_uop),
        .iss_vld   (o_iss_vld),
        .iss_uop   (o_iss_uop)
    );

    task automatic stop_with_failure();
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[FAIL] %s expected 0x%0h got 0x%0h", name, exp, got);
        stop_with_failure();
    endtask

    task automatic report_error(input string msg);
        $display("%s", msg);
        stop_with_failure();
    endtask

    function automatic int unsigned next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    function automatic int unsigned assertion_failures();
        return uut.u_wb_net.u_wb_asrt.fail_count
             + uut.u_pipe0.u_queue.u_iq_asrt.fail_count
             + uut.u_pipe1.u_queue.u_iq_asrt.fail_count;
    endfunction

    task automatic load_testdata();
        int base;
        exp_known = '0;
        $readmemh("verif/int_block_testdata.hex", tdata);
        assert (!$isunknown(tdata[NUM_UOPS*NUM_FIELDS-1]))
        else report_error("test data file is missing or too short");
        for (int i = 0; i < NUM_UOPS; i++) begin
            base = i * NUM_FIELDS;
            uops[i].op      = alu_op_e'(tdata[base][2:0]);
            uops[i].use_imm = tdata[base + 1][0];
            uops[i].imm     = tdata[base + 2];
            uops[i].src[0]  = preg_t'(tdata[base + 3]);
            uops[i].src[1]  = preg_t'(tdata[base + 4]);
            uops[i].src_rdy = {tdata[base + 6][0], tdata[base + 5][0]};
            uops[i].dst     = preg_t'(tdata[base + 7]);
            assert (!exp_known[uops[i].dst])
            else report_error("test data targets one preg twice");
            exp_val[uops[i].dst]   = tdata[base + 8];
            exp_known[uops[i].dst] = 1'b1;
        end
    endtask

    task automatic wait_for_reset();
        int cycles;
        cycles = 0;
        while (rst !== 1'b0) begin
            @(negedge clk);
            cycles++;
            assert (cycles < RESET_TIMEOUT) else report_error("reset was never released");
        end
    endtask

    // slot 1 carries the next micro-op, so a refused slot 1 moves to slot 0
    task automatic drive_offer(input int ptr);
        disp_vld[0] = 1'b1;
        disp_uop[0] = uops[ptr];
        if (ptr + 1 < NUM_UOPS) begin
            disp_vld[1] = 1'b1;
            disp_uop[1] = uops[ptr + 1];
        end else begin
            disp_vld[1] = 1'b0;
            disp_uop[1] = '0;
        end
    endtask

    task automatic check_accept();
        assert (!$isunknown(disp_accept)) else report_error("o_disp_accept is unknown");
        assert ((disp_accept & ~disp_vld) == '0)
        else report_error("o_disp_accept raised for a slot with no offer");
        assert (!(disp_accept[1] && disp_vld[0] && !disp_accept[0]))
        else report_error("slot 1 accepted while slot 0 was refused");
    endtask

    task automatic check_writeback();
        preg_t idx;
        assert (!$isunknown(wb_vld)) else report_error("o_wb_vld is unknown");
        for (int p = 0; p < NUM_PIPES; p++) begin
            if (wb_vld[p]) begin
                idx = wb_preg[p];
                assert (exp_known[idx])
                else report_error($sformatf(
                    "pipe %0d wrote back preg %0d, which no micro-op targets", p, idx));
                assert (!seen[idx])
                else report_error($sformatf("preg %0d was written back twice", idx));
                assert (wb_data[p] === exp_val[idx])
                else report_mismatch($sformatf("o_wb_data[%0d]", p), exp_val[idx], wb_data[p]);
                seen[idx] = 1'b1;
                wb_count++;
            end
        end
        assert (assertion_failures() == 0) else report_error("a bound assertion failed");
    endtask

    // writeback outputs are registered and stable at the falling edge
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            check_writeback();
        end
    end

    initial begin
        int   ptr;
        int   taken;
        int   stall;
        int   gap;
        logic held;
        disp_vld    = '0;
        disp_uop[0] = '0;
        disp_uop[1] = '0;
        lcg_state   = 32'd82341;
        seen        = '0;
        wb_count    = 0;
        bp_cycles   = 0;
        load_testdata();
        wait_for_reset();

        ptr   = 0;
        stall = 0;
        held  = 1'b0;
        while (ptr < NUM_UOPS) begin
            // idle cycles only between fully accepted offers
            if (ptr < PAUSE_END && !held) begin
                gap = int'(next_random() % 3);
                for (int i = 0; i < gap; i++) begin
                    @(negedge clk);
                    disp_vld = '0;
                end
            end
            @(negedge clk);
            drive_offer(ptr);
            #SETTLE;
            check_accept();
            taken = int'(disp_accept[0]) + int'(disp_accept[1]);
            held  = (disp_accept != disp_vld);
            if (held) begin
                bp_cycles++;
            end
            stall = (taken == 0) ? stall + 1 : 0;
            assert (stall < ACCEPT_TIMEOUT) else report_error("timeout waiting for o_disp_accept");
            ptr += taken;
        end
        @(negedge clk);
        disp_vld = '0;

        stall = 0;
        while (wb_count < NUM_UOPS) begin
            @(negedge clk);
            #SETTLE;
            stall++;
            assert (stall < DRAIN_TIMEOUT)
            else report_error($sformatf("timeout with %0d of %0d results written back",
                                        wb_count, NUM_UOPS));
        end
        // stray or repeated writebacks would show up here
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            @(negedge clk);
        end
        #SETTLE;

        assert (seen == exp_known) else report_mismatch("written-back preg set", exp_known, seen);
        assert (bp_cycles > 0) else report_error("dispatch back-pressure was never seen");
        assert (assertion_failures() == 0) else report_error("a bound assertion failed");
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/int_block_testdata.hex ====
// columns: op use_imm imm src0 src1 rdy0 rdy1 dst expected
// op codes 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 slt
0 1 1234 00 00 1 1 01 1234
3 1 00f0 00 00 1 1 02 00f0
4 1 a5a5 00 00 1 1 03 a5a5
1 1 0003 00 00 1 1 04 fffd
0 0 0000 01 02 0 0 05 1324
1 0 0000 03 01 0 0 06 9371
2 1 0ff0 03 00 0 1 07 05a0
2 0 0000 05 06 0 0 08 1320
3 0 0000 07 02 0 0 09 05f0
4 0 0000 09 08 0 0 0a 16d0
5 1 0004 01 00 0 1 0b 2340
6 1 0005 03 00 0 1 0c 052d
7 1 0001 04 00 0 1 0d 0001
7 0 0000 02 04 0 0 0e 0000
5 0 0000 0d 0c 0 0 0f 2000
6 0 0000 0f 0d 0 0 10 1000
0 0 0000 10 0b 0 0 11 3340
1 0 0000 11 0a 0 0 12 1c70
4 1 ffff 12 00 0 1 13 e38f
7 0 0000 13 12 0 0 14 0001
0 1 7ffe 14 00 0 1 15 7fff
0 1 0001 15 00 0 1 16 8000
6 1 000f 16 00 0 1 17 0001
5 1 0003 17 00 0 1 18 0008
3 0 0000 18 11 0 0 19 3348
2 1 00ff 19 00 0 1 1a 0048
1 1 0050 1a 00 0 1 1b fff8
7 0 0000 1b 0e 0 0 1c 0001
4 0 0000 1c 1b 0 0 1d fff9
5 0 0000 1d 18 0 0 1e f900

// ==== list.f ====
common/int_pkg.sv
common/exe_if.sv
issue_pipe/issue_queue.sv
issue_pipe/issue_pipe.sv
hdl/writeback_net.sv
hdl/int_block.sv
verif/tb_clock.sv
verif/int_block_assertions.sv
verif/int_block_tb.sv

// ==== Bender.yml ====
package:
  name: int_block

sources:
  - common/int_pkg.sv
  - common/exe_if.sv
  - issue_pipe/issue_queue.sv
  - issue_pipe/issue_pipe.sv
  - hdl/writeback_net.sv
  - hdl/int_block.sv
  - target: test
    files:
      - verif/tb_clock.sv
      - verif/int_block_assertions.sv
      - verif/int_block_tb.sv
